//--- Makefile
# Verilator build and run for the delta-modulation channel testbench

VERILATOR ?= verilator
TOP ?= tb_dmc_channel
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -Wno-fatal

BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- source/dmc_buffer_if.sv
// Sample byte handover from the reader into the output side buffer
`timescale 1ns/1ps
`default_nettype none

interface dmc_buffer_if;

	logic byte_valid;				// One-cycle strobe with a fetched byte
	dmc_pkg::byte_t byte_data;
	logic buffer_empty;				// Buffer state, owned by the player

	modport reader (
		output byte_valid, byte_data,
		input buffer_empty
	);

	modport player (
		input byte_valid, byte_data,
		output buffer_empty
	);

endinterface

`default_nettype wire

//--- source/dmc_channel.sv
// Delta-modulation sample channel top, register, reader and output blocks
`timescale 1ns/1ps
`default_nettype none

module dmc_channel (
	input wire aclk,
	input wire reset,
	input wire write_ctrl,
	input wire write_level,
	input wire write_addr,
	input wire write_len,
	input wire write_status,
	input wire dmc_pkg::byte_t write_data,
	input wire dma_ack,
	input wire dmc_pkg::byte_t dma_data,
	output wire dma_req,
	output wire dmc_pkg::addr_t dma_addr,
	output wire irq,
	output wire active,
	output wire dmc_pkg::level_t level
);

	wire bytes_remaining_zero;	// Reader count state for restart decode

	dmc_config_if cfg_bus ();
	dmc_buffer_if sample_bus ();

	dmc_regs regs_i (
		.aclk(aclk),
		.reset(reset),
		.write_ctrl(write_ctrl),
		.write_addr(write_addr),
		.write_len(write_len),
		.write_status(write_status),
		.write_data(write_data),
		.bytes_remaining_zero(bytes_remaining_zero),
		.cfg(cfg_bus.regs)
	);

	dmc_sample_reader reader_i (
		.aclk(aclk),
		.reset(reset),
		.dma_ack(dma_ack),
		.dma_data(dma_data),
		.dma_req(dma_req),
		.dma_addr(dma_addr),
		.irq(irq),
		.active(active),
		.bytes_remaining_zero(bytes_remaining_zero),
		.cfg(cfg_bus.reader),
		.buf_if(sample_bus.reader)
	);

	dmc_output_unit output_i (
		.aclk(aclk),
		.reset(reset),
		.write_level(write_level),
		.write_data(write_data),
		.level(level),
		.cfg(cfg_bus.player),
		.buf_if(sample_bus.player)
	);

endmodule

`default_nettype wire

//--- source/dmc_config_if.sv
// Channel settings bus from the register block to the reader and the output side
`timescale 1ns/1ps
`default_nettype none

interface dmc_config_if;

	dmc_pkg::rate_idx_t rate_idx;
	logic loop_mode;
	logic irq_enable;
	dmc_pkg::byte_t start_reg;		// Raw start address register
	dmc_pkg::byte_t length_reg;		// Raw length register
	logic enable;
	logic restart;					// One-cycle pulse, reload the reader
	logic irq_clear;				// One-cycle pulse, drop the interrupt

	modport regs (
		output rate_idx, loop_mode, irq_enable, start_reg, length_reg,
		output enable, restart, irq_clear
	);

	modport reader (
		input loop_mode, irq_enable, start_reg, length_reg,
		input enable, restart, irq_clear
	);

	modport player (
		input rate_idx
	);

endinterface

`default_nettype wire

//--- source/dmc_output_unit.sv
// Output side with rate timer, sample buffer, shifter and delta level counter
`timescale 1ns/1ps
`default_nettype none

module dmc_output_unit (
	input wire aclk,
	input wire reset,
	input wire write_level,
	input wire dmc_pkg::byte_t write_data,
	output dmc_pkg::level_t level,
	dmc_config_if.player cfg,
	dmc_buffer_if.player buf_if
);

	dmc_pkg::period_t timer_q;
	dmc_pkg::bit_cnt_t bits_left;
	dmc_pkg::byte_t sample_buf;
	dmc_pkg::byte_t shift_q;
	logic tick;
	logic byte_end;
	logic silent;		// No byte was there at the last reload
	logic level_up;
	logic level_down;

	assign tick = (timer_q == '0);
	assign byte_end = tick && (bits_left == 4'd1);

	// Clamp so the counter neither overflows nor goes below zero
	assign level_up = shift_q[0] &&
		(level <= dmc_pkg::LEVEL_MAX - dmc_pkg::LEVEL_STEP);
	assign level_down = !shift_q[0] && (level >= dmc_pkg::LEVEL_STEP);

	// Reload with period minus one so ticks are one period apart
	always_ff @(posedge aclk) begin
		if (reset)
			timer_q <= '0;
		else if (tick)
			timer_q <= dmc_pkg::RATE_PERIODS[cfg.rate_idx] - 9'd1;
		else
			timer_q <= timer_q - 9'd1;
	end

	always_ff @(posedge aclk) begin
		if (reset) begin
			bits_left <= dmc_pkg::BITS_PER_BYTE;
			silent <= 1'b1;
			buf_if.buffer_empty <= 1'b1;
		end else begin
			if (byte_end)
				bits_left <= dmc_pkg::BITS_PER_BYTE;
			else if (tick)
				bits_left <= bits_left - 4'd1;

			if (byte_end)
				silent <= buf_if.buffer_empty;	// Starve if nothing arrived

			if (buf_if.byte_valid)
				buf_if.buffer_empty <= 1'b0;
			else if (byte_end)
				buf_if.buffer_empty <= 1'b1;	// Shifter took the byte
		end
	end

	always_ff @(posedge aclk) begin
		if (buf_if.byte_valid)
			sample_buf <= buf_if.byte_data;

		if (byte_end && !buf_if.buffer_empty)
			shift_q <= sample_buf;
		else if (tick)
			shift_q <= shift_q >> 1;	// LSB first
	end

	always_ff @(posedge aclk) begin
		if (reset)
			level <= '0;
		else if (write_level)
			level <= write_data[6:0];	// Direct load wins over a tick
		else if (tick && !silent) begin
			if (level_up)
				level <= level + dmc_pkg::LEVEL_STEP;
			else if (level_down)
				level <= level - dmc_pkg::LEVEL_STEP;
		end
	end

	// Level moves one step at a time and never wraps past LEVEL_MAX or zero
	a_level_in_range: assert property (@(posedge aclk) disable iff (reset)
		(!$past(write_level) && $changed(level)) |->
		(({1'b0, level} == {1'b0, $past(level)} + {1'b0, dmc_pkg::LEVEL_STEP}) ||
		({1'b0, level} + {1'b0, dmc_pkg::LEVEL_STEP} == {1'b0, $past(level)})))
		else $error("dmc_output_unit: level left its range");

endmodule

`default_nettype wire

//--- source/dmc_pkg.sv
// Delta-modulation channel package with constants, rate periods and shared types
`default_nettype none

package dmc_pkg;

	typedef logic [15:0] addr_t;	// Sample memory address
	typedef logic [6:0] level_t;	// Output level for the DAC
	typedef logic [7:0] byte_t;		// Register or sample byte
	typedef logic [3:0] rate_idx_t;	// Index into the period table
	typedef logic [8:0] period_t;	// Timer period in aclk cycles
	typedef logic [11:0] length_t;	// Sample bytes still to fetch
	typedef logic [3:0] bit_cnt_t;	// Bits left in the shifter

	// One entry per rate index, replaces the LFSR and its decoder
	localparam period_t RATE_PERIODS [16] = '{
		9'd214,
		9'd190,
		9'd170,
		9'd160,
		9'd143,
		9'd127,
		9'd113,
		9'd107,
		9'd95,
		9'd80,
		9'd71,
		9'd64,
		9'd53,
		9'd42,
		9'd36,
		9'd27
	};

	localparam addr_t ADDR_BASE = 16'hC000;		// First possible sample start
	localparam int ADDR_SHIFT = 6;				// Start register counts 64-byte blocks
	localparam int LEN_SHIFT = 4;				// Length register counts 16-byte blocks
	localparam addr_t ADDR_WRAP = 16'h8000;		// Address after 0xFFFF

	localparam level_t LEVEL_MAX = 7'd127;
	localparam level_t LEVEL_STEP = 7'd2;		// Level change per sample bit
	localparam bit_cnt_t BITS_PER_BYTE = 4'd8;

	localparam int CTRL_LOOP_BIT = 6;			// Control register, loop playback
	localparam int CTRL_IRQ_BIT = 7;			// Control register, interrupt enable
	localparam int STATUS_ENABLE_BIT = 4;		// Status register, channel enable

endpackage

`default_nettype wire

//--- source/dmc_regs.sv
// Channel register block, decodes the write strobes into settings and pulses
`timescale 1ns/1ps
`default_nettype none

module dmc_regs (
	input wire aclk,
	input wire reset,
	input wire write_ctrl,
	input wire write_addr,
	input wire write_len,
	input wire write_status,
	input wire dmc_pkg::byte_t write_data,
	input wire bytes_remaining_zero,
	dmc_config_if.regs cfg
);

	logic enable_bit;	// Enable bit of a status write

	assign enable_bit = write_data[dmc_pkg::STATUS_ENABLE_BIT];

	always_ff @(posedge aclk) begin
		if (reset) begin
			cfg.rate_idx <= '0;
			cfg.loop_mode <= 1'b0;
			cfg.irq_enable <= 1'b0;
			cfg.enable <= 1'b0;
			cfg.restart <= 1'b0;
			cfg.irq_clear <= 1'b0;
		end else begin
			if (write_ctrl) begin
				cfg.rate_idx <= write_data[3:0];
				cfg.loop_mode <= write_data[dmc_pkg::CTRL_LOOP_BIT];
				cfg.irq_enable <= write_data[dmc_pkg::CTRL_IRQ_BIT];
			end
			if (write_status)
				cfg.enable <= enable_bit;

			// Start a sample when turned on, or when idle and enabled again
			cfg.restart <= write_status && enable_bit &&
				(!cfg.enable || bytes_remaining_zero);
			cfg.irq_clear <= write_status ||
				(write_ctrl && !write_data[dmc_pkg::CTRL_IRQ_BIT]);
		end
	end

	always_ff @(posedge aclk) begin
		if (write_addr)
			cfg.start_reg <= write_data;
		if (write_len)
			cfg.length_reg <= write_data;
	end

	// Register writes come from one CPU store at a time
	a_one_write: assert property (@(posedge aclk) disable iff (reset)
		$onehot0({write_ctrl, write_addr, write_len, write_status}))
		else $error("dmc_regs: more than one write strobe in a cycle");

endmodule

`default_nettype wire

//--- source/dmc_sample_reader.sv
// Sample reader with fetch request, address and byte counters, loop and interrupt
`timescale 1ns/1ps
`default_nettype none

module dmc_sample_reader (
	input wire aclk,
	input wire reset,
	input wire dma_ack,
	input wire dmc_pkg::byte_t dma_data,
	output logic dma_req,
	output dmc_pkg::addr_t dma_addr,
	output logic irq,
	output logic active,
	output logic bytes_remaining_zero,
	dmc_config_if.reader cfg,
	dmc_buffer_if.reader buf_if
);

	dmc_pkg::addr_t addr_q;
	dmc_pkg::addr_t next_addr;
	dmc_pkg::addr_t start_addr;
	dmc_pkg::length_t count_q;
	dmc_pkg::length_t start_count;
	logic fetch_done;
	logic last_byte;
	logic reload;

	assign start_addr = dmc_pkg::ADDR_BASE +
		(dmc_pkg::addr_t'(cfg.start_reg) << dmc_pkg::ADDR_SHIFT);
	assign start_count = (dmc_pkg::length_t'(cfg.length_reg) << dmc_pkg::LEN_SHIFT) + 12'd1;
	assign next_addr = (addr_q == 16'hFFFF) ? dmc_pkg::ADDR_WRAP : addr_q + 16'd1;	// Wrap into ROM

	assign bytes_remaining_zero = (count_q == '0);
	assign last_byte = (count_q == 12'd1);

	// Hold off while a fetched byte is still on its way into the buffer
	assign dma_req = cfg.enable && !bytes_remaining_zero &&
		buf_if.buffer_empty && !buf_if.byte_valid;
	assign fetch_done = dma_req && dma_ack;	// Stray acks are dropped
	assign reload = cfg.restart || (fetch_done && last_byte && cfg.loop_mode);

	assign dma_addr = addr_q;
	assign active = cfg.enable && !bytes_remaining_zero;

	always_ff @(posedge aclk) begin
		if (reset) begin
			count_q <= '0;
			irq <= 1'b0;
			buf_if.byte_valid <= 1'b0;
		end else begin
			buf_if.byte_valid <= fetch_done;

			if (!cfg.enable)
				count_q <= '0;	// Disable stops the sample
			else if (reload)
				count_q <= start_count;
			else if (fetch_done)
				count_q <= count_q - 12'd1;

			if (cfg.loop_mode)
				irq <= 1'b0;	// Looping samples never interrupt
			else if (fetch_done && last_byte && cfg.irq_enable)
				irq <= 1'b1;
			else if (cfg.irq_clear)
				irq <= 1'b0;
		end
	end

	always_ff @(posedge aclk) begin
		if (reload)
			addr_q <= start_addr;
		else if (fetch_done)
			addr_q <= next_addr;

		if (fetch_done)
			buf_if.byte_data <= dma_data;
	end

	// Memory may stretch the ack, the address must not move meanwhile
	a_addr_stable: assert property (@(posedge aclk) disable iff (reset)
		(dma_req && $past(dma_req)) |-> $stable(dma_addr))
		else $error("dmc_sample_reader: dma_addr moved during a request");

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// Testbench clock source, free-running square wave
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;	// Half period per phase
	end

endmodule

`default_nettype wire

//--- testbench/tb_dmc_channel.sv
// Delta-modulation channel testbench with memory model, stimulus and checking assertions
`timescale 1ns/1ps
`default_nettype none

module tb_dmc_channel;

	localparam int TIMEOUT_CYCLES = 20000;
	localparam logic [2:0] SEL_CTRL = 3'd0;
	localparam logic [2:0] SEL_LEVEL = 3'd1;
	localparam logic [2:0] SEL_ADDR = 3'd2;
	localparam logic [2:0] SEL_LEN = 3'd3;
	localparam logic [2:0] SEL_STATUS = 3'd4;

	logic aclk;
	logic reset;
	logic write_ctrl;
	logic write_level;
	logic write_addr;
	logic write_len;
	logic write_status;
	dmc_pkg::byte_t write_data;
	logic dma_ack;
	dmc_pkg::byte_t dma_data;
	logic dma_req;
	dmc_pkg::addr_t dma_addr;
	logic irq;
	logic active;
	dmc_pkg::level_t level;

	// Reference model of the fetch side
	dmc_pkg::addr_t exp_addr;
	dmc_pkg::addr_t exp_start;
	int exp_len;
	int acks_left;
	int loops_done;
	int ack_delay;
	logic loop_on;
	logic irq_on;
	logic irq_expected;
	logic chan_enabled;
	logic ones_mode;	// Memory returns 0xFF instead of random data
	logic hold_check;
	logic rate_check;
	logic [31:0] rng;
	dmc_pkg::level_t level_written;

	// Previous-cycle copies of the output side
	dmc_pkg::level_t level_q = '0;
	logic level_wr_q = 1'b0;
	logic gap_valid = 1'b0;
	int gap = 0;		// Cycles since the last level change

	tb_clock_gen #(.PERIOD_NS(40)) clock_i (.clk(aclk));

	dmc_channel dut_i (
		.aclk(aclk),
		.reset(reset),
		.write_ctrl(write_ctrl),
		.write_level(write_level),
		.write_addr(write_addr),
		.write_len(write_len),
		.write_status(write_status),
		.write_data(write_data),
		.dma_ack(dma_ack),
		.dma_data(dma_data),
		.dma_req(dma_req),
		.dma_addr(dma_addr),
		.irq(irq),
		.active(active),
		.level(level)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic report_failure();
		$display("Test FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	// One strobe for one cycle, starting at a falling edge
	task automatic write_reg(input logic [2:0] sel, input dmc_pkg::byte_t value);
		write_data = value;
		write_ctrl = (sel == SEL_CTRL);
		write_level = (sel == SEL_LEVEL);
		write_addr = (sel == SEL_ADDR);
		write_len = (sel == SEL_LEN);
		write_status = (sel == SEL_STATUS);
		if (sel == SEL_LEVEL)
			level_written = value[6:0];
		@(negedge aclk);
		{write_ctrl, write_level, write_addr, write_len, write_status} = '0;
		if (sel == SEL_STATUS)
			chan_enabled = value[4];
		if (sel == SEL_STATUS || (sel == SEL_CTRL && !value[7])) begin
			@(negedge aclk);
			irq_expected = 1'b0;	// Clear pulse lands one cycle later
		end
	endtask

	task automatic start_sample(input dmc_pkg::byte_t ctrl, input dmc_pkg::byte_t start,
		input dmc_pkg::byte_t len);
		write_reg(SEL_CTRL, ctrl);
		write_reg(SEL_ADDR, start);
		write_reg(SEL_LEN, len);
		exp_start = 16'hC000 + (16'(start) << 6);	// Base plus 64-byte blocks
		exp_len = int'(len) * 16 + 1;
		exp_addr = exp_start;
		acks_left = exp_len;
		loops_done = 0;
		loop_on = ctrl[6];
		irq_on = ctrl[7];
		write_reg(SEL_STATUS, 8'h10);
	endtask

	task automatic wait_level(input dmc_pkg::level_t target);
		int n;
		n = 0;
		while (level !== target && n < TIMEOUT_CYCLES) begin
			@(negedge aclk);
			n++;
		end
		if (level !== target) begin
			$display("Timeout while waiting for level %0d", target);
			report_failure();
		end
	endtask

	task automatic await_irq();
		int n;
		n = 0;
		while (irq !== 1'b1 && n < TIMEOUT_CYCLES) begin
			@(negedge aclk);
			n++;
		end
		if (irq !== 1'b1) begin
			$display("Timeout while waiting for the end-of-sample interrupt");
			report_failure();
		end
	endtask

	task automatic count_loops(input int target);
		int n;
		n = 0;
		while (loops_done < target && n < TIMEOUT_CYCLES) begin
			@(negedge aclk);
			n++;
		end
		if (loops_done < target) begin
			$display("Timeout while waiting for %0d sample loops", target);
			report_failure();
		end
	endtask

	// Memory with random ack delay, also advances the fetch model
	always @(negedge aclk) begin
		if (reset) begin
			dma_ack = 1'b0;
			ack_delay = -1;
		end else if (dma_ack) begin
			dma_ack = 1'b0;		// Taken at the edge just passed
			acks_left = acks_left - 1;
			exp_addr = (exp_addr == 16'hFFFF) ? 16'h8000 : exp_addr + 16'd1;
			if (acks_left == 0 && loop_on) begin
				acks_left = exp_len;
				exp_addr = exp_start;
				loops_done++;
			end else if (acks_left == 0 && irq_on)
				irq_expected = 1'b1;
		end else if (!dma_req)
			ack_delay = -1;
		else begin
			if (ack_delay < 0) begin
				rng = lcg_next(rng);
				ack_delay = int'(rng[18:16]) % 6;
			end
			if (ack_delay == 0) begin
				rng = lcg_next(rng);
				dma_data = ones_mode ? 8'hFF : rng[23:16];
				dma_ack = 1'b1;
				ack_delay = -1;
			end else
				ack_delay--;
		end
	end

	always @(posedge aclk) begin
		level_q <= level;
		level_wr_q <= write_level;
		if (level_wr_q) begin
			gap <= 1;
			gap_valid <= 1'b0;	// Interval restarts after a direct load
		end else if (level != level_q) begin
			gap <= 1;
			gap_valid <= 1'b1;
		end else
			gap <= gap + 1;
	end

	a_addr_seq: assert property (@(posedge aclk) disable iff (reset)
		(dma_req && dma_ack) |-> (dma_addr == exp_addr))
		else begin
			$display("ERR %0t dma_addr expected %h got %h", $time, exp_addr, dma_addr);
			report_failure();
		end

	a_len_limit: assert property (@(posedge aclk) disable iff (reset)
		(dma_req && dma_ack) |-> (acks_left != 0))
		else begin
			$display("A fetch was acknowledged after the last sample byte");
			report_failure();
		end

	a_done_quiet: assert property (@(posedge aclk) disable iff (reset)
		(!loop_on && acks_left == 0) |-> (!dma_req && !active))
		else begin
			$display("ERR %0t dma_req/active expected 0/0 got %0b/%0b", $time, dma_req, active);
			report_failure();
		end

	a_irq_model: assert property (@(posedge aclk) disable iff (reset)
		irq == irq_expected)
		else begin
			$display("ERR %0t irq expected %0b got %0b", $time, irq_expected, irq);
			report_failure();
		end

	a_disabled_quiet: assert property (@(posedge aclk) disable iff (reset)
		!chan_enabled |-> (!dma_req && !active))
		else begin
			$display("ERR %0t dma_req/active expected 0/0 got %0b/%0b", $time, dma_req, active);
			report_failure();
		end

	a_level_write: assert property (@(posedge aclk) disable iff (reset)
		level_wr_q |-> (level == level_written))
		else begin
			$display("ERR %0t level expected %0d got %0d", $time, level_written, level);
			report_failure();
		end

	a_level_step: assert property (@(posedge aclk) disable iff (reset)
		(!level_wr_q && level != level_q) |->
		({1'b0, level} == {1'b0, level_q} + 8'd2 || {1'b0, level} + 8'd2 == {1'b0, level_q}))
		else begin
			$display("ERR %0t level stepped from %0d to %0d", $time, level_q, level);
			report_failure();
		end

	a_level_hold: assert property (@(posedge aclk) disable iff (reset)
		(hold_check && !level_wr_q && level_q == 7'd126) |-> (level == 7'd126))
		else begin
			$display("ERR %0t level expected 126 got %0d", $time, level);
			report_failure();
		end

	a_rate_gap: assert property (@(posedge aclk) disable iff (reset)
		(rate_check && gap_valid && !level_wr_q && level != level_q) |-> (gap == 27))
		else begin
			$display("ERR %0t level change interval expected 27 got %0d", $time, gap);
			report_failure();
		end

	initial begin
		reset = 1'b1;
		{write_ctrl, write_level, write_addr, write_len, write_status} = '0;
		write_data = '0;
		dma_ack = 1'b0;
		dma_data = '0;
		rng = 32'd19622;
		{exp_addr, exp_start} = '0;
		{exp_len, acks_left, loops_done} = '0;
		ack_delay = -1;
		{loop_on, irq_on, irq_expected, chan_enabled} = '0;
		{ones_mode, hold_check, rate_check} = '0;
		level_written = '0;
		repeat (10) @(negedge aclk);
		reset = 1'b0;

		// All-ones data at the fastest rate, climb and clamp
		ones_mode = 1'b1;
		hold_check = 1'b1;
		rate_check = 1'b1;
		write_reg(SEL_LEVEL, 8'd120);
		start_sample(8'h4F, 8'h00, 8'h00);
		wait_level(7'd126);
		repeat (400) @(negedge aclk);	// Let the clamp run for a while
		write_reg(SEL_LEVEL, 8'd0);
		wait_level(7'd126);
		write_reg(SEL_STATUS, 8'h00);
		{ones_mode, hold_check, rate_check} = '0;

		// Start at 0xFFC0 so the fetch wraps, then interrupt
		start_sample(8'h8F, 8'hFF, 8'h04);
		await_irq();
		write_reg(SEL_STATUS, 8'h00);

		// Looping sample with interrupt enabled, then disable mid-sample
		start_sample(8'hCF, 8'h10, 8'h01);
		count_loops(2);
		write_reg(SEL_STATUS, 8'h00);
		repeat (100) @(negedge aclk);

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
source/dmc_pkg.sv
source/dmc_config_if.sv
source/dmc_buffer_if.sv
source/dmc_regs.sv
source/dmc_sample_reader.sv
source/dmc_output_unit.sv
source/dmc_channel.sv
testbench/tb_clock_gen.sv
testbench/tb_dmc_channel.sv
